// File: hdl/tankGame_consts.svh
`ifndef TANKGAME_CONSTS_SVH
`define TANKGAME_CONSTS_SVH

// Visible raster, limits themselves count as on screen
`define PIXELS_HORIZ 640
`define PIXELS_VERT 480

// 32 pixel tiles on a 20 by 15 grid
`define TILE_SHIFT 5
`define GRID_COLS 20
`define GRID_ROWS 15

// Tank box spans position to position plus width, inclusive
`define TANK_WIDTH 25
`define TANK_START_X 40
`define TANK_START_Y 40

// Flat 12-bit RGB colours
`define COLOUR_FLOOR 12'hEEE
`define COLOUR_WALL 12'hA42
`define COLOUR_BRICK 12'hC63
`define COLOUR_COIN 12'hFD0
`define COLOUR_TANK 12'h2A2
`define COLOUR_OFFSCREEN 12'h222

`endif

// File: hdl/tankGamePkg.sv
package tankGamePkg;

	// Map contents, wall and brick block the tank
	typedef enum logic [3:0]
	{
		tileFloor = 4'd0,
		tileWall = 4'd1,
		tileBrick = 4'd2,
		tileCoin = 4'd3
	} tileCode;

	// Last direction the tank was driven
	typedef enum logic [1:0]
	{
		dirUp,
		dirDown,
		dirLeft,
		dirRight
	} tankDirection;

	// Col is x, row is y
	typedef struct packed
	{
		logic [9:0] col;
		logic [9:0] row;
	} pixelPos;

	typedef struct packed
	{
		logic [4:0] tileCol;
		logic [3:0] tileRow;
	} tileIndex;

	typedef struct packed
	{
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbColour;

	// Corner order is fixed: TL, TR, BL, BR
	typedef struct packed
	{
		tileCode topLeft;
		tileCode topRight;
		tileCode bottomLeft;
		tileCode bottomRight;
	} cornerTiles;

	typedef struct packed
	{
		tileIndex topLeft;
		tileIndex topRight;
		tileIndex bottomLeft;
		tileIndex bottomRight;
	} cornerIndices;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
	} buttonSet;

endpackage

// File: hdl/tileMap.sv
`include "tankGame_consts.svh"

module tileMap import tankGamePkg::*;
(
	input logic Master_Clock_In,
	input logic reset,
	input tileIndex decodedTile,
	output tileCode pixelTile,
	input cornerIndices cornerIdx,
	output cornerTiles corners,
	input logic coinClear,
	input tileIndex coinTile
);

	// Row major tile store
	tileCode mapArray [`GRID_ROWS][`GRID_COLS];

	// Combinational lookup of one tile
	function automatic tileCode readTile(tileIndex idx);
		return mapArray[idx.tileRow][idx.tileCol];
	endfunction

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Pixel path, index already clamped upstream
	assign pixelTile = readTile(decodedTile);

	// Tank corner probes
	assign corners.topLeft = readTile(cornerIdx.topLeft);
	assign corners.topRight = readTile(cornerIdx.topRight);
	assign corners.bottomLeft = readTile(cornerIdx.bottomLeft);
	assign corners.bottomRight = readTile(cornerIdx.bottomRight);

	//////////////////////////////
	// Reset pattern and coin clear
	//////////////////////////////

	always_ff @(posedge Master_Clock_In)
	begin
		if (reset)
		begin
			for (int r = 0; r < `GRID_ROWS; r++)
			begin
				for (int c = 0; c < `GRID_COLS; c++)
				begin
					// Wall ring on the border
					if (r == 0 || r == `GRID_ROWS - 1 || c == 0 || c == `GRID_COLS - 1)
						mapArray[r][c] <= tileWall;
					// Coin lattice every fourth tile, offset 2
					else if (r % 4 == 2 && c % 4 == 2)
						mapArray[r][c] <= tileCoin;
					else
						mapArray[r][c] <= tileFloor;
				end
			end
		end
		else if (coinClear)
			mapArray[coinTile.tileRow][coinTile.tileCol] <= tileFloor;
	end

	// Tank logic only collects tiles that really hold a coin
	assert property (@(posedge Master_Clock_In) disable iff (reset)
		coinClear |-> mapArray[coinTile.tileRow][coinTile.tileCol] == tileCoin);

endmodule

// File: hdl/pixelDecode.sv
`include "tankGame_consts.svh"

module pixelDecode import tankGamePkg::*;
(
	input logic Master_Clock_In,
	input logic reset,
	input pixelPos pixel,
	input logic displayEnable,
	output pixelPos decodedPixel,
	output logic decodedEnable,
	output tileIndex decodedTile
);

	// Raw tile coordinates, may point past the grid
	logic [4:0] rawCol;
	logic [4:0] rawRow;
	tileIndex nextTile;

	assign rawCol = pixel.col[9:`TILE_SHIFT];
	assign rawRow = pixel.row[9:`TILE_SHIFT];

	//////////////////////////////
	// Tile index with clamp
	//////////////////////////////

	// Off-grid pixels read the last tile, colour stage overrides them
	assign nextTile.tileCol = (rawCol > 5'(`GRID_COLS - 1)) ? 5'(`GRID_COLS - 1) : rawCol;
	assign nextTile.tileRow = (rawRow > 5'(`GRID_ROWS - 1)) ? 4'(`GRID_ROWS - 1) : rawRow[3:0];

	// Enable is the only control bit here
	always_ff @(posedge Master_Clock_In)
	begin
		if (reset)
			decodedEnable <= 1'b0;
		else
			decodedEnable <= displayEnable;
	end

	// Pixel payload follows the enable
	always_ff @(posedge Master_Clock_In)
	begin
		decodedPixel <= pixel;
		decodedTile <= nextTile;
	end

endmodule

// File: hdl/tankUpdate.sv
`include "tankGame_consts.svh"

module tankUpdate import tankGamePkg::*;
(
	input logic Master_Clock_In,
	input logic reset,
	input pixelPos pixel,
	input logic displayEnable,
	input buttonSet buttons,
	output cornerIndices cornerIdx,
	input cornerTiles corners,
	output logic coinClear,
	output tileIndex coinTile,
	output pixelPos tankPosition,
	output logic [7:0] coinCount
);

	logic frameEnd;
	logic [9:0] rightEdge;
	logic [9:0] bottomEdge;
	logic solidTl;
	logic solidTr;
	logic solidBl;
	logic solidBr;
	logic coinHit;
	pixelPos nextPos;

	function automatic logic isSolid(tileCode code);
		return code == tileWall || code == tileBrick;
	endfunction

	function automatic tileIndex toTile(logic [9:0] x, logic [9:0] y);
		return '{tileCol: x[9:`TILE_SHIFT], tileRow: y[`TILE_SHIFT+3:`TILE_SHIFT]};
	endfunction

	// Last pixel of the frame, one update per frame
	assign frameEnd = displayEnable && pixel.col == 10'(`PIXELS_HORIZ)
		&& pixel.row == 10'(`PIXELS_VERT);

	//////////////////////////////
	// Corner probes
	//////////////////////////////

	assign rightEdge = tankPosition.col + 10'(`TANK_WIDTH);
	assign bottomEdge = tankPosition.row + 10'(`TANK_WIDTH);
	assign cornerIdx.topLeft = toTile(tankPosition.col, tankPosition.row);
	assign cornerIdx.topRight = toTile(rightEdge, tankPosition.row);
	assign cornerIdx.bottomLeft = toTile(tankPosition.col, bottomEdge);
	assign cornerIdx.bottomRight = toTile(rightEdge, bottomEdge);

	assign solidTl = isSolid(corners.topLeft);
	assign solidTr = isSolid(corners.topRight);
	assign solidBl = isSolid(corners.bottomLeft);
	assign solidBr = isSolid(corners.bottomRight);

	//////////////////////////////
	// Action priority
	//////////////////////////////

	always_comb
	begin
		nextPos = tankPosition;
		coinHit = 1'b0;
		coinTile = cornerIdx.topLeft;
		// Edge pairs push straight back
		if (solidBl && solidBr)
			nextPos.row = tankPosition.row - 10'd1;
		else if (solidTl && solidBl)
			nextPos.col = tankPosition.col + 10'd1;
		else if (solidTl && solidTr)
			nextPos.row = tankPosition.row + 10'd1;
		else if (solidTr && solidBr)
			nextPos.col = tankPosition.col - 10'd1;
		// Lone corner pushes diagonally away
		else if (solidTl)
			nextPos = '{col: tankPosition.col + 10'd1, row: tankPosition.row + 10'd1};
		else if (solidTr)
			nextPos = '{col: tankPosition.col - 10'd1, row: tankPosition.row + 10'd1};
		else if (solidBl)
			nextPos = '{col: tankPosition.col + 10'd1, row: tankPosition.row - 10'd1};
		else if (solidBr)
			nextPos = '{col: tankPosition.col - 10'd1, row: tankPosition.row - 10'd1};
		// First coin corner gets collected
		else if (corners.topLeft == tileCoin)
			coinHit = 1'b1;
		else if (corners.topRight == tileCoin)
		begin
			coinHit = 1'b1;
			coinTile = cornerIdx.topRight;
		end
		else if (corners.bottomLeft == tileCoin)
		begin
			coinHit = 1'b1;
			coinTile = cornerIdx.bottomLeft;
		end
		else if (corners.bottomRight == tileCoin)
		begin
			coinHit = 1'b1;
			coinTile = cornerIdx.bottomRight;
		end
		// Buttons last, up then right then down then left
		else if (buttons.up)
			nextPos.row = tankPosition.row - 10'd1;
		else if (buttons.right)
			nextPos.col = tankPosition.col + 10'd1;
		else if (buttons.down)
			nextPos.row = tankPosition.row + 10'd1;
		else if (buttons.left)
			nextPos.col = tankPosition.col - 10'd1;
	end

	// Map write lands on the same frame-end edge
	assign coinClear = frameEnd && coinHit;

	always_ff @(posedge Master_Clock_In)
	begin
		if (reset)
		begin
			tankPosition <= '{col: 10'(`TANK_START_X), row: 10'(`TANK_START_Y)};
			coinCount <= 8'd0;
		end
		else if (frameEnd)
		begin
			tankPosition <= nextPos;
			if (coinHit)
				coinCount <= coinCount + 8'd1;
		end
	end

	// Wall ring keeps the whole box on screen
	assert property (@(posedge Master_Clock_In) disable iff (reset)
		tankPosition.col <= 10'(`PIXELS_HORIZ - 1 - `TANK_WIDTH)
		&& tankPosition.row <= 10'(`PIXELS_VERT - 1 - `TANK_WIDTH));

endmodule

// File: hdl/pixelColour.sv
`include "tankGame_consts.svh"

module pixelColour import tankGamePkg::*;
(
	input logic Master_Clock_In,
	input logic reset,
	input pixelPos decodedPixel,
	input logic decodedEnable,
	input tileCode pixelTile,
	input pixelPos tankPosition,
	output rgbColour colour
);

	logic offScreen;
	logic inTank;
	rgbColour tileRgb;

	// Limits are inclusive, so 640 and 480 still draw
	assign offScreen = decodedPixel.col > 10'(`PIXELS_HORIZ)
		|| decodedPixel.row > 10'(`PIXELS_VERT);

	// Inclusive tank box
	assign inTank = decodedPixel.col >= tankPosition.col
		&& decodedPixel.col <= tankPosition.col + `TANK_WIDTH
		&& decodedPixel.row >= tankPosition.row
		&& decodedPixel.row <= tankPosition.row + `TANK_WIDTH;

	//////////////////////////////
	// Tile palette
	//////////////////////////////

	always_comb
	begin
		case (pixelTile)
			tileWall: tileRgb = `COLOUR_WALL;
			tileBrick: tileRgb = `COLOUR_BRICK;
			tileCoin: tileRgb = `COLOUR_COIN;
			default: tileRgb = `COLOUR_FLOOR;
		endcase
	end

	// Blank, off screen, tank, then map
	always_ff @(posedge Master_Clock_In)
	begin
		if (reset)
			colour <= '0;
		else if (!decodedEnable)
			colour <= '0;
		else if (offScreen)
			colour <= `COLOUR_OFFSCREEN;
		else if (inTank)
			colour <= `COLOUR_TANK;
		else
			colour <= tileRgb;
	end

endmodule

// File: hdl/tankGameDraw.sv
module tankGameDraw import tankGamePkg::*;
(
	input logic Master_Clock_In,
	input logic reset,
	input logic displayEnable,
	input pixelPos pixel,
	input buttonSet buttons,
	output rgbColour colour,
	output logic [7:0] coinCount,
	output pixelPos tankPosition
);

	// Decode stage to map and colour
	pixelPos decodedPixel;
	logic decodedEnable;
	tileIndex decodedTile;
	tileCode pixelTile;

	// Tank logic to map
	cornerIndices cornerIdx;
	cornerTiles corners;
	logic coinClear;
	tileIndex coinTile;

	//////////////////////////////
	// Pixel pipeline
	//////////////////////////////

	pixelDecode i_pixelDecode
	(
		.Master_Clock_In(Master_Clock_In),
		.reset(reset),
		.pixel(pixel),
		.displayEnable(displayEnable),
		.decodedPixel(decodedPixel),
		.decodedEnable(decodedEnable),
		.decodedTile(decodedTile)
	);

	tileMap i_tileMap
	(
		.Master_Clock_In(Master_Clock_In),
		.reset(reset),
		.decodedTile(decodedTile),
		.pixelTile(pixelTile),
		.cornerIdx(cornerIdx),
		.corners(corners),
		.coinClear(coinClear),
		.coinTile(coinTile)
	);

	pixelColour i_pixelColour
	(
		.Master_Clock_In(Master_Clock_In),
		.reset(reset),
		.decodedPixel(decodedPixel),
		.decodedEnable(decodedEnable),
		.pixelTile(pixelTile),
		.tankPosition(tankPosition),
		.colour(colour)
	);

	//////////////////////////////
	// Frame-end game state
	//////////////////////////////

	// Sees the raw pixel to catch frame end
	tankUpdate i_tankUpdate
	(
		.Master_Clock_In(Master_Clock_In),
		.reset(reset),
		.pixel(pixel),
		.displayEnable(displayEnable),
		.buttons(buttons),
		.cornerIdx(cornerIdx),
		.corners(corners),
		.coinClear(coinClear),
		.coinTile(coinTile),
		.tankPosition(tankPosition),
		.coinCount(coinCount)
	);

endmodule

// File: sim/tankGameModel.svh
`ifndef TANKGAMEMODEL_SVH
`define TANKGAMEMODEL_SVH

// Reference copy of the game state, updated by the testbench itself
tileCode refMap [`GRID_ROWS][`GRID_COLS];
int tankX;
int tankY;
int coinTotal;

// Border ring of walls, coins on the 4-by-4 lattice offset by 2
function automatic void resetReference();
	for (int r = 0; r < `GRID_ROWS; r++)
	begin
		for (int c = 0; c < `GRID_COLS; c++)
		begin
			if (r == 0 || c == 0 || r == `GRID_ROWS - 1 || c == `GRID_COLS - 1)
				refMap[r][c] = tileWall;
			else if (r % 4 == 2 && c % 4 == 2)
				refMap[r][c] = tileCoin;
			else
				refMap[r][c] = tileFloor;
		end
	end
	tankX = `TANK_START_X;
	tankY = `TANK_START_Y;
	coinTotal = 0;
endfunction

// Expected colour of one pixel with the current tank position
function automatic int predictColour(int col, int row, bit enable);
	int tileCol;
	int tileRow;
	tileCol = (col / 32 > `GRID_COLS - 1) ? `GRID_COLS - 1 : col / 32;
	tileRow = (row / 32 > `GRID_ROWS - 1) ? `GRID_ROWS - 1 : row / 32;
	if (!enable)
		return 0;
	if (col > `PIXELS_HORIZ || row > `PIXELS_VERT)
		return `COLOUR_OFFSCREEN;
	if (col >= tankX && col <= tankX + `TANK_WIDTH && row >= tankY && row <= tankY + `TANK_WIDTH)
		return `COLOUR_TANK;
	case (refMap[tileRow][tileCol])
		tileWall: return `COLOUR_WALL;
		tileBrick: return `COLOUR_BRICK;
		tileCoin: return `COLOUR_COIN;
		default: return `COLOUR_FLOOR;
	endcase
endfunction

// One frame-end step, corners in the order TL, TR, BL, BR
function automatic void applyFrameRules(buttonSet press);
	int cornerX [4];
	int cornerY [4];
	bit solid [4];
	bit collected;
	cornerX = '{tankX, tankX + `TANK_WIDTH, tankX, tankX + `TANK_WIDTH};
	cornerY = '{tankY, tankY, tankY + `TANK_WIDTH, tankY + `TANK_WIDTH};
	collected = 1'b0;
	for (int k = 0; k < 4; k++)
		solid[k] = refMap[cornerY[k] / 32][cornerX[k] / 32] inside {tileWall, tileBrick};
	// Edge pairs first
	if (solid[2] && solid[3])
		tankY = tankY - 1;
	else if (solid[0] && solid[2])
		tankX = tankX + 1;
	else if (solid[0] && solid[1])
		tankY = tankY + 1;
	else if (solid[1] && solid[3])
		tankX = tankX - 1;
	// Then single corners, diagonal push
	else if (solid[0])
	begin
		tankX = tankX + 1;
		tankY = tankY + 1;
	end
	else if (solid[1])
	begin
		tankX = tankX - 1;
		tankY = tankY + 1;
	end
	else if (solid[2])
	begin
		tankX = tankX + 1;
		tankY = tankY - 1;
	end
	else if (solid[3])
	begin
		tankX = tankX - 1;
		tankY = tankY - 1;
	end
	else
	begin
		for (int k = 0; k < 4; k++)
		begin
			if (!collected && refMap[cornerY[k] / 32][cornerX[k] / 32] == tileCoin)
			begin
				refMap[cornerY[k] / 32][cornerX[k] / 32] = tileFloor;
				coinTotal = coinTotal + 1;
				collected = 1'b1;
			end
		end
		// No coin taken, buttons decide
		if (!collected)
		begin
			if (press.up)
				tankY = tankY - 1;
			else if (press.right)
				tankX = tankX + 1;
			else if (press.down)
				tankY = tankY + 1;
			else if (press.left)
				tankX = tankX - 1;
		end
	end
endfunction

`endif

// File: sim/tankGameTb.sv
`include "tankGame_consts.svh"

module tankGameTb import tankGamePkg::*;
();

	// Test sizes, also used for the cycle budget
	localparam int BLANK_PIXELS = 200;
	localparam int MAP_PIXELS = 2000;
	localparam int FRAME_COUNT = 300;
	localparam int COIN_TILES = 15;
	localparam int TEST_CYCLES = 17 + (BLANK_PIXELS + 2) + (MAP_PIXELS + 2) + FRAME_COUNT
		+ (COIN_TILES + 2) + 1;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic Master_Clock_In;
	logic reset;
	logic displayEnable;
	pixelPos pixel;
	buttonSet buttons;
	rgbColour colour;
	logic [7:0] coinCount;
	pixelPos tankPosition;

	integer seed = 32'h4647_4034;
	int checkCount = 0;
	int errorCount = 0;
	int testChecksStart = 0;
	int testErrorsStart = 0;
	int cycleCount;
	// Expected colours of the pixels still inside the pipeline
	int expectQueue [$];

	`include "tankGameModel.svh"

	tankGameDraw i_tankGameDraw
	(
		.Master_Clock_In(Master_Clock_In),
		.reset(reset),
		.displayEnable(displayEnable),
		.pixel(pixel),
		.buttons(buttons),
		.colour(colour),
		.coinCount(coinCount),
		.tankPosition(tankPosition)
	);

	//////////////////////////////
	// Clock and cycle budget
	//////////////////////////////

	initial
	begin
		Master_Clock_In = 1'b0;
		forever #5 Master_Clock_In = ~Master_Clock_In;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge Master_Clock_In);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Inputs change 1 unit after the edge
	task automatic nextCycle();
		@(posedge Master_Clock_In);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		end
	endtask

	task automatic reportTest(input string testName);
		$display("%s done: %0d checks, %0d errors", testName, checkCount - testChecksStart,
			errorCount - testErrorsStart);
		testChecksStart = checkCount;
		testErrorsStart = errorCount;
	endtask

	// Colour of a pixel shows two edges after it is driven
	task automatic drivePixel(input int col, input int row, input bit enable);
		if (expectQueue.size() == 2)
			checkValue("colour", colour, expectQueue.pop_front());
		pixel = '{col: 10'(col), row: 10'(row)};
		displayEnable = enable;
		expectQueue.push_back(predictColour(col, row, enable));
		nextCycle();
	endtask

	// Drain the pipeline and check what is left
	task automatic flushPixels();
		displayEnable = 1'b0;
		while (expectQueue.size() > 0)
		begin
			checkValue("colour", colour, expectQueue.pop_front());
			nextCycle();
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int col;
		int row;
		buttonSet press;
		bit insideRing;
		reset = 1'b1;
		displayEnable = 1'b0;
		pixel = '0;
		buttons = '0;
		resetReference();
		repeat (16) @(posedge Master_Clock_In);
		#1;
		reset = 1'b0;

		// Reset values
		checkValue("colour", colour, 0);
		checkValue("coinCount", coinCount, 0);
		checkValue("tankPosition.col", tankPosition.col, `TANK_START_X);
		checkValue("tankPosition.row", tankPosition.row, `TANK_START_Y);
		reportTest("reset state");

		for (int i = 0; i < BLANK_PIXELS; i++)
			drivePixel($unsigned($random(seed)) % 1024, $unsigned($random(seed)) % 1024, 1'b0);
		flushPixels();
		reportTest("blanking");

		// Some pixels land past the visible limits
		for (int i = 0; i < MAP_PIXELS; i++)
		begin
			col = $unsigned($random(seed)) % 704;
			row = $unsigned($random(seed)) % 528;
			// Keep the tank still, frame end only in the next test
			if (col == `PIXELS_HORIZ && row == `PIXELS_VERT)
				row = row - 1;
			drivePixel(col, row, 1'b1);
		end
		flushPixels();
		reportTest("map rendering");

		for (int f = 0; f < FRAME_COUNT; f++)
		begin
			press = 4'($random(seed));
			pixel = '{col: 10'(`PIXELS_HORIZ), row: 10'(`PIXELS_VERT)};
			displayEnable = 1'b1;
			buttons = press;
			applyFrameRules(press);
			nextCycle();
			displayEnable = 1'b0;
			checkValue("tankPosition.col", tankPosition.col, tankX);
			checkValue("tankPosition.row", tankPosition.row, tankY);
			// Push-back allows a single pixel of overlap with the ring
			insideRing = tankPosition.col >= 31 && tankPosition.row >= 31
				&& tankPosition.col <= 608 - `TANK_WIDTH && tankPosition.row <= 448 - `TANK_WIDTH;
			checkValue("tank box inside wall ring", insideRing, 1);
		end
		reportTest("movement and push-back");

		// Centre of every lattice tile, collected ones draw as floor
		buttons = '0;
		checkValue("coinCount", coinCount, coinTotal);
		for (int r = 2; r < `GRID_ROWS - 1; r += 4)
		begin
			for (int c = 2; c < `GRID_COLS - 1; c += 4)
				drivePixel(c * 32 + 16, r * 32 + 16, 1'b1);
		end
		flushPixels();
		reportTest("coin pickup");

		$display("tests run: 5, checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+hdl
+incdir+sim
hdl/tankGamePkg.sv
hdl/tileMap.sv
hdl/pixelDecode.sv
hdl/tankUpdate.sv
hdl/pixelColour.sv
hdl/tankGameDraw.sv
sim/tankGameTb.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tankGameTb -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/VtankGameTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
